//--- rtl/pc_io_defs.svh
// Field widths and port codes are fixed to the PC-8001 layout; changing a width needs RTL review
`ifndef PC_IO_DEFS_SVH
`define PC_IO_DEFS_SVH

// Palette and video
`define PAL_ENTRIES 8
`define COLOR_W     3       // bit 0 blue, bit 1 red, bit 2 green
`define VGA_W       4

// Audio
`define PSG_W       10
`define DAC_W       11
`define BEEP_LEVEL  128

// Full port addresses
`define PORT_SYS    8'h30
`define PORT_STAT   8'h40
`define PORT_SD     8'hFD

// Upper nibble only
`define PORT_PAL    4'h9
`define PORT_BANK   4'hE

// Bank register sub-addresses
`define BANK_OFF    4'h0
`define BANK_CFG    4'h2
`define BANK_SEL    4'h7

// Write data bit positions
`define MOTOR_BIT   3
`define BEEP_BIT    5
`define BANK_EN_BIT 0
`define BANK_WP_BIT 4

// Read data bases and the live bits patched into them
`define STAT_RD     8'h0E
`define VSYNC_BIT   5
`define SD_STAT_RD  8'hEF
`define SD_DAT_BIT  4

`endif

//--- rtl/pc_io_pkg.sv
// Types only; struct field order is the bit order seen at the pins, first field on top
`include "pc_io_defs.svh"

package pc_io_pkg;

	// One CPU I/O request, valid for the single cycle req is high
	typedef struct packed {
		logic       req;
		logic       wr;
		logic [7:0] addr;
		logic [7:0] wdata;
	} io_bus_t;

	typedef logic [`COLOR_W-1:0] color_t;
	typedef logic [$clog2(`PAL_ENTRIES)-1:0] pal_idx_t;

	typedef struct packed {
		logic     valid;
		pal_idx_t index;
		color_t   colour;
	} pal_wr_t;

	typedef struct packed {
		logic       en_ext_ram;
		logic       we_ext_ram;
		logic [3:0] sel_ram;    // One bit per 8 KB region below 8000h
	} bank_cfg_t;

	typedef enum logic [1:0] {
		SRC_RAM,
		SRC_BIOS,
		SRC_EXT,
		SRC_NONE    // Open bus, reads as FFh
	} mem_src_e;

	// CRTC dot attributes
	typedef struct packed {
		logic g;
		logic r;
		logic b;
		logic lumi;
		logic vsafe;    // Inside the visible area
		logic scanln;   // Odd line of a doubled scanline
	} dot_t;

	typedef struct packed {
		logic [`VGA_W-1:0] r;
		logic [`VGA_W-1:0] g;
		logic [`VGA_W-1:0] b;
	} rgb_t;

	typedef logic [`PSG_W-1:0] psg_sample_t;

endpackage

//--- rtl/io_decoder.sv
// Single-cycle requests with no back-pressure; the palette strobe is decoded straight from io
`timescale 1ns/10ps
`include "pc_io_defs.svh"

module io_decoder import pc_io_pkg::*; (
	input  logic       clk,
	input  logic       reset_n,
	input  io_bus_t    io,
	input  logic       vsync,
	input  logic       sd_dat,
	output logic [7:0] rdata,
	output logic       rd_valid,
	output pal_wr_t    pal_wr,
	output bank_cfg_t  bank,
	output logic       beep_gate,
	output logic       motor,
	output logic [7:0] sd_out
);

	localparam logic [7:0] SD_PORT = `PORT_SD;

	logic       wr_req;
	logic       rd_req;
	logic [3:0] hi;
	logic [3:0] lo;
	logic [7:0] rd_mux;

	assign wr_req = io.req & io.wr;
	assign rd_req = io.req & ~io.wr;
	assign hi = io.addr[7:4];
	assign lo = io.addr[3:0];

	// 98h-9Fh belonged to full-dot colour and fall through
	always_comb begin
		pal_wr.valid = wr_req && hi == `PORT_PAL && !lo[3];
		pal_wr.index = lo[2:0];
		pal_wr.colour = io.wdata[`COLOR_W-1:0];
	end

	// System, beep and SD latches
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			motor <= 1'b0;
			beep_gate <= 1'b0;
			sd_out <= 8'h00;
		end else if (wr_req) begin
			if (io.addr == `PORT_SYS)
				motor <= io.wdata[`MOTOR_BIT];
			if (io.addr == `PORT_STAT)
				beep_gate <= io.wdata[`BEEP_BIT];
			if (io.addr == `PORT_SD)
				sd_out <= io.wdata;     // Bits 0-2 drive the card pins
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			bank.en_ext_ram <= 1'b0;
			bank.we_ext_ram <= 1'b1;
			bank.sel_ram <= 4'hF;
		end else if (wr_req && hi == `PORT_BANK) begin
			case (lo)
				`BANK_OFF: bank.en_ext_ram <= 1'b0;
				`BANK_CFG: begin
					bank.en_ext_ram <= io.wdata[`BANK_EN_BIT];
					bank.we_ext_ram <= io.wdata[`BANK_WP_BIT];
				end
				`BANK_SEL: bank.sel_ram <= io.wdata[7:4];
				default: ;
			endcase
		end
	end

	// Read mux, only 40h and Fxh are live
	always_comb begin
		if (io.addr == `PORT_STAT) begin
			rd_mux = `STAT_RD;
			rd_mux[`VSYNC_BIT] = vsync;
		end else if (io.addr == `PORT_SD) begin
			rd_mux = sd_out;
		end else if (hi == SD_PORT[7:4]) begin
			rd_mux = `SD_STAT_RD;
			rd_mux[`SD_DAT_BIT] = sd_dat;     // Card busy / data line
		end else begin
			rd_mux = 8'hFF;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n)
			rd_valid <= 1'b0;
		else
			rd_valid <= rd_req;
	end

	always_ff @(posedge clk) begin
		if (rd_req)
			rdata <= rd_mux;
	end

endmodule

//--- rtl/color_palette.sv
// vga lags dot by one clock; a palette write shows from the dot sampled one edge after it
`timescale 1ns/10ps
`include "pc_io_defs.svh"

module color_palette import pc_io_pkg::*; (
	input  logic    clk,
	input  logic    reset_n,
	input  pal_wr_t pal_wr,
	input  dot_t    dot,
	input  logic    scanline_en,
	input  logic    green_mode,
	output rgb_t    vga
);

	color_t pal [`PAL_ENTRIES];
	color_t fg;
	color_t bg;
	logic   dim;
	logic   any_dot;
	rgb_t   vga_next;

	// One colour channel from palette bits
	function automatic logic [`VGA_W-1:0] chan(
		input logic fg_bit,
		input logic bg_bit,
		input logic lumi,
		input logic vsafe,
		input logic half
	);
		logic [`VGA_W-1:0] lvl;
		lvl = {`VGA_W{lumi ? fg_bit : bg_bit}};
		if (!vsafe)
			lvl = '0;
		else if (half)
			lvl = lvl >> 1;
		return lvl;
	endfunction

	assign fg = pal[{dot.g, dot.r, dot.b}];
	assign bg = pal[0];    // Entry 0 doubles as background
	assign dim = dot.scanln & scanline_en;
	assign any_dot = dot.g | dot.r | dot.b;

	always_comb begin
		if (green_mode) begin
			vga_next.r = '0;
			vga_next.b = '0;
			if (dot.vsafe && dot.lumi && any_dot)
				vga_next.g = dim ? {1'b0, dot.g, dot.r, dot.b} : {dot.g, dot.r, dot.b, 1'b1};
			else
				vga_next.g = `VGA_W'(1);     // Faint phosphor glow
		end else begin
			vga_next.r = chan(fg[1], bg[1], dot.lumi, dot.vsafe, dim);
			vga_next.g = chan(fg[2], bg[2], dot.lumi, dot.vsafe, dim);
			vga_next.b = chan(fg[0], bg[0], dot.lumi, dot.vsafe, dim);
		end
	end

	// Identity palette out of reset
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < `PAL_ENTRIES; i++)
				pal[i] <= color_t'(i);
		end else if (pal_wr.valid) begin
			pal[pal_wr.index] <= pal_wr.colour;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n)
			vga <= '0;
		else
			vga <= vga_next;
	end

endmodule

//--- rtl/mem_map.sv
// Purely combinational; the memories themselves and their read data are outside this block
`timescale 1ns/10ps

module mem_map import pc_io_pkg::*; (
	input  bank_cfg_t   bank,
	input  logic        ext_rom_en,
	input  logic [15:0] mem_addr,
	input  logic        mem_wr,
	output mem_src_e    mem_src,
	output logic        ram_we
);

	logic [2:0] region;
	logic       ram_sel;

	assign region = mem_addr[15:13];    // 8 KB regions

	// Only meaningful for regions 0-3
	assign ram_sel = bank.en_ext_ram & bank.sel_ram[region[1:0]];

	always_comb begin
		case (region)
			3'd0, 3'd1, 3'd2: begin
				mem_src = ram_sel ? SRC_RAM : SRC_BIOS;
			end
			3'd3: begin
				// 6000h-7FFFh holds the optional extension ROM
				if (ram_sel)
					mem_src = SRC_RAM;
				else if (ext_rom_en)
					mem_src = SRC_EXT;
				else
					mem_src = SRC_NONE;
			end
			default: mem_src = SRC_RAM;     // Upper 32 KB is always RAM
		endcase
	end

	// Lower half is write protected unless we_ext_ram
	assign ram_we = mem_wr & (mem_addr[15] | bank.we_ext_ram);

endmodule

//--- rtl/audio_dac.sv
// The mix wraps past 7FFh when both samples are near full scale with the beep on
`timescale 1ns/10ps
`include "pc_io_defs.svh"

module audio_dac import pc_io_pkg::*; (
	input  logic        clk,
	input  logic        reset_n,
	input  psg_sample_t psg_a,
	input  psg_sample_t psg_b,
	input  logic        beep_gate,
	input  logic        tone,
	output logic        beep_out,
	output logic        dac_out
);

	logic [`DAC_W-1:0] level;
	logic [`DAC_W-1:0] acc;
	logic [`DAC_W:0]   sum;

	assign beep_out = beep_gate & tone;     // Gated square wave, also to the speaker pin

	// Mixer
	assign level = `DAC_W'(psg_a) + `DAC_W'(psg_b) +
		(beep_out ? `DAC_W'(`BEEP_LEVEL) : `DAC_W'(0));

	// First-order loop, carry out is the pulse density
	assign sum = {1'b0, level} + {1'b0, acc};

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			acc <= '0;
			dac_out <= 1'b0;
		end else begin
			acc <= sum[`DAC_W-1:0];
			dac_out <= sum[`DAC_W];
		end
	end

endmodule

//--- rtl/pc_io_top.sv
// No registers here, so pin timing equals the submodule timing; reset_n is used unstretched
`timescale 1ns/10ps

module pc_io_top import pc_io_pkg::*; (
	input  logic        clk,
	input  logic        reset_n,
	input  io_bus_t     io,
	input  logic        vsync,
	input  logic        sd_dat,
	output logic [7:0]  rdata,
	output logic        rd_valid,
	input  dot_t        dot,
	input  logic        scanline_en,
	input  logic        green_mode,
	output rgb_t        vga,
	input  logic        ext_rom_en,
	input  logic [15:0] mem_addr,
	input  logic        mem_wr,
	output mem_src_e    mem_src,
	output logic        ram_we,
	input  psg_sample_t psg_a,
	input  psg_sample_t psg_b,
	input  logic        tone,
	output logic        dac_out,
	output logic        motor_out,
	output logic        beep_out,
	output logic        sd_clk,
	output logic        sd_cmd,
	output logic        sd_res
);

	pal_wr_t    pal_wr;
	bank_cfg_t  bank;
	logic       beep_gate;
	logic [7:0] sd_out;

	io_decoder u_io_decoder (
		.clk       (clk),
		.reset_n   (reset_n),
		.io        (io),
		.vsync     (vsync),
		.sd_dat    (sd_dat),
		.rdata     (rdata),
		.rd_valid  (rd_valid),
		.pal_wr    (pal_wr),
		.bank      (bank),
		.beep_gate (beep_gate),
		.motor     (motor_out),
		.sd_out    (sd_out)
	);

	color_palette u_color_palette (
		.clk         (clk),
		.reset_n     (reset_n),
		.pal_wr      (pal_wr),
		.dot         (dot),
		.scanline_en (scanline_en),
		.green_mode  (green_mode),
		.vga         (vga)
	);

	mem_map u_mem_map (
		.bank       (bank),
		.ext_rom_en (ext_rom_en),
		.mem_addr   (mem_addr),
		.mem_wr     (mem_wr),
		.mem_src    (mem_src),
		.ram_we     (ram_we)
	);

	audio_dac u_audio_dac (
		.clk       (clk),
		.reset_n   (reset_n),
		.psg_a     (psg_a),
		.psg_b     (psg_b),
		.beep_gate (beep_gate),
		.tone      (tone),
		.beep_out  (beep_out),
		.dac_out   (dac_out)
	);

	// SD card pins from the FDh latch
	assign sd_clk = sd_out[0];
	assign sd_cmd = sd_out[1];
	assign sd_res = sd_out[2];

endmodule

//--- dv/tb_pc_io.sv
// One fixed LCG seed drives all stimulus; the DAC test resets again so its model starts at zero
`timescale 1ns/10ps
`include "pc_io_defs.svh"

module tb_pc_io import pc_io_pkg::*; ();

	logic clk, reset_n, vsync, sd_dat, rd_valid, scanline_en, green_mode;
	logic ext_rom_en, mem_wr, ram_we, tone, dac_out, motor_out, beep_out;
	logic sd_clk, sd_cmd, sd_res;
	logic [7:0]  rdata, sd_m;
	logic [15:0] mem_addr;
	logic [10:0] acc_m;
	logic [31:0] seed;
	logic        beep_m, vga_chk, dac_chk, dac_exp;
	io_bus_t     io;
	dot_t        dot;
	rgb_t        vga, vga_exp;
	mem_src_e    mem_src;
	psg_sample_t psg_a, psg_b;
	bank_cfg_t   bank_m;
	color_t      pal_m [`PAL_ENTRIES];
	int          errors, checks, tests;

	pc_io_top uut (.*);

	always #4 clk = ~clk;

	// Expected values are set on the previous falling edge
	always @(negedge clk) begin
		if (vga_chk)
			check("vga", 32'(vga), 32'(vga_exp));
		if (dac_chk)
			check("dac_out", 32'(dac_out), 32'(dac_exp));
	end

	function automatic logic [31:0] rand32();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed ^ (seed >> 15);     // Low LCG bits have short periods
	endfunction

	function automatic rgb_t exp_vga(input dot_t d, input logic scan, input logic green);
		color_t     c;
		logic       dim;
		logic [3:0] lv [3];
		c = d.lumi ? pal_m[{d.g, d.r, d.b}] : pal_m[0];     // Background when lumi is off
		dim = d.scanln & scan;
		for (int k = 0; k < 3; k++)
			lv[k] = !d.vsafe ? 4'h0 : dim ? {1'b0, {3{c[k]}}} : {4{c[k]}};
		if (!green)
			return {lv[1], lv[2], lv[0]};
		if (d.vsafe && d.lumi && {d.g, d.r, d.b} != 3'b000)
			return {4'h0, (dim ? {1'b0, d.g, d.r, d.b} : {d.g, d.r, d.b, 1'b1}), 4'h0};
		return {4'h0, 4'h1, 4'h0};
	endfunction

	function automatic mem_src_e exp_src(input logic [15:0] addr, input logic ext);
		logic hit;
		hit = bank_m.en_ext_ram & bank_m.sel_ram[addr[14:13]];
		if (addr[15] || hit)
			return SRC_RAM;
		if (addr[14:13] != 2'd3)
			return SRC_BIOS;
		return ext ? SRC_EXT : SRC_NONE;
	endfunction

	function automatic logic [7:0] exp_rd(input logic [7:0] addr);
		if (addr == 8'h40)
			return {2'b00, vsync, 5'b01110};
		if (addr == 8'hFD)
			return sd_m;
		if (addr[7:4] == 4'hF)
			return {3'b111, sd_dat, 4'hF};
		return 8'hFF;
	endfunction

	// Result is {carry, next accumulator}
	function automatic logic [11:0] dac_step(input logic [10:0] acc, input psg_sample_t a,
			input psg_sample_t b, input logic beep);
		logic [10:0] level;
		level = 11'(a) + 11'(b) + (beep ? 11'(`BEEP_LEVEL) : 11'd0);
		return {1'b0, acc} + {1'b0, level};
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d (%s) finished, %0d errors so far", tests, name, errors);
	endtask

	task automatic apply_reset();
		reset_n = 1'b0;
		for (int i = 0; i < `PAL_ENTRIES; i++)
			pal_m[i] = color_t'(i);
		bank_m = '{en_ext_ram: 1'b0, we_ext_ram: 1'b1, sel_ram: 4'hF};
		sd_m = 8'h00;
		beep_m = 1'b0;
		acc_m = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
	endtask

	task automatic io_write(input logic [7:0] addr, input logic [7:0] data);
		@(negedge clk);
		io = {1'b1, 1'b1, addr, data};
		@(negedge clk);
		io = '0;
	endtask

	task automatic io_read(input logic [7:0] addr);
		int cycles;
		@(negedge clk);
		io = {1'b1, 1'b0, addr, 8'h00};
		@(negedge clk);
		io = '0;
		cycles = 1;
		while (!rd_valid && cycles < 8) begin
			@(negedge clk);
			cycles++;
		end
		if (!rd_valid) begin
			$display("Timeout: no rd_valid within 8 cycles of a read of port %h", addr);
			$display("*** FAILED ***");
			$finish;
		end else begin
			check("rd_valid latency", 32'(cycles), 32'd1);
			check("rdata", 32'(rdata), 32'(exp_rd(addr)));
			@(negedge clk);
			check("rd_valid", 32'(rd_valid), 32'd0);     // One-cycle pulse
		end
	endtask

	task automatic sweep_dots(input int n, input logic scan, input logic green);
		logic [31:0] r;
		repeat (n) begin
			@(negedge clk);
			r = rand32();
			dot = r[5:0];
			scanline_en = scan;
			green_mode = green;
			vga_exp <= exp_vga(r[5:0], scan, green);
			vga_chk <= 1'b1;
		end
		@(negedge clk);
		vga_chk <= 1'b0;
	endtask

	initial begin
		logic [31:0] r;
		logic [7:0]  a;
		logic [11:0] step;
		clk = 1'b0;
		io = '0;
		dot = '0;
		mem_addr = '0;
		psg_a = '0;
		psg_b = '0;
		{vsync, sd_dat, scanline_en, green_mode, ext_rom_en, mem_wr, tone} = '0;
		vga_chk <= 1'b0;
		dac_chk <= 1'b0;
		errors = 0;
		checks = 0;
		tests = 0;
		seed = 32'hcb769462;
		apply_reset();
		check("motor_out", 32'(motor_out), 32'd0);
		check("sd_res/sd_cmd/sd_clk", 32'({sd_res, sd_cmd, sd_clk}), 32'd0);

		sweep_dots(32, 1'b0, 1'b0);     // Identity palette
		for (int i = 0; i < `PAL_ENTRIES; i++) begin
			r = rand32();
			io_write(8'h90 | 8'(i), r[7:0]);
			pal_m[i] = r[2:0];
		end
		r = rand32();
		io_write({5'b10011, r[2:0]}, r[7:0]);     // 98h-9Fh must leave the palette alone
		sweep_dots(32, 1'b0, 1'b0);
		end_test("palette");

		for (int m = 0; m < 4; m++)
			sweep_dots(24, m[0], m[1]);
		end_test("scanline and green mode");

		for (int k = 0; k < 6; k++) begin
			r = rand32();
			if (k % 3 == 2) begin
				r[0] = 1'b1;     // RAM on in every low region so the E0h clear shows
				r[15:12] = 4'hF;
			end
			io_write(8'hE2, r[7:0]);
			io_write(8'hE7, r[15:8]);
			bank_m = '{en_ext_ram: r[0], we_ext_ram: r[4], sel_ram: r[15:12]};
			if (k % 3 == 2) begin
				io_write(8'hE0, r[23:16]);
				bank_m.en_ext_ram = 1'b0;
			end
			for (int i = 0; i < 16; i++) begin
				@(negedge clk);
				r = rand32();
				{mem_wr, mem_addr} = r[16:0];
				ext_rom_en = i[0];
				#1;
				check("mem_src", 32'(mem_src), 32'(exp_src(mem_addr, ext_rom_en)));
				check("ram_we", 32'(ram_we), 32'(mem_wr & (mem_addr[15] | bank_m.we_ext_ram)));
			end
		end
		end_test("memory map");

		vsync = 1'b0;
		io_read(8'h40);
		vsync = 1'b1;
		io_read(8'h40);
		r = rand32();
		io_write(8'hFD, r[7:0]);
		sd_m = r[7:0];
		io_read(8'hFD);
		for (int i = 0; i < 8; i++) begin
			r = rand32();
			a = {4'hF, r[3:0]};
			if (a == 8'hFD)
				a = 8'hF0;
			sd_dat = i[0];
			io_read(a);
			a = r[15:8];
			if (a == 8'h40 || a[7:4] == 4'hF)
				a = a ^ 8'h80;     // Move it onto an unmapped port
			io_read(a);
		end
		end_test("read ports");

		io_write(8'h30, 8'h08);
		check("motor_out", 32'(motor_out), 32'd1);
		io_write(8'h30, 8'hF7);
		check("motor_out", 32'(motor_out), 32'd0);
		io_write(8'h40, 8'h20);
		for (int i = 0; i < 4; i++) begin
			@(negedge clk);
			tone = i[0];
			#1;
			check("beep_out", 32'(beep_out), 32'(i[0]));
		end
		io_write(8'h40, 8'hDF);     // Gate off with tone still high
		#1;
		check("beep_out", 32'(beep_out), 32'd0);
		for (int i = 0; i < 4; i++) begin
			r = rand32();
			io_write(8'hFD, r[7:0]);
			check("sd_res/sd_cmd/sd_clk", 32'({sd_res, sd_cmd, sd_clk}), 32'(r[2:0]));
		end
		end_test("system outputs");

		apply_reset();
		for (int i = 0; i < 320; i++) begin
			@(negedge clk);
			r = rand32();
			psg_a = r[9:0];
			psg_b = r[25:16];
			tone = r[31];
			io = (i % 40 == 20) ? {1'b1, 1'b1, 8'h40, 2'b00, ~beep_m, 5'b00000} : '0;
			step = dac_step(acc_m, r[9:0], r[25:16], beep_m & r[31]);
			acc_m = step[10:0];
			dac_exp <= step[11];
			dac_chk <= 1'b1;
			beep_m = beep_m ^ io.req;     // Gate switches at the coming edge
		end
		@(negedge clk);
		io = '0;
		dac_chk <= 1'b0;
		end_test("audio DAC");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+rtl
rtl/pc_io_pkg.sv
rtl/io_decoder.sv
rtl/color_palette.sv
rtl/mem_map.sv
rtl/audio_dac.sv
rtl/pc_io_top.sv
dv/tb_pc_io.sv

//--- run.sh
#!/bin/sh
# Builds with Verilator, runs the testbench and scans the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -f verilog.f --top-module tb_pc_io \
	-Mdir obj_dir -o sim_pc_io
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_pc_io > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qF '*** FAILED ***' sim.log; then
	exit 1
fi
exit 0
